//--- Bender.yml
package:
  name: dma_subsys

sources:
  - files:
      - hdl/dma_reg_pkg.sv
      - hdl/dma_job_pkg.sv
      - hdl/dma_fifo.sv
      - hdl/dma_reg_frontend.sv
      - hdl/dma_channel.sv
      - hdl/dma_mem_arbiter.sv
      - hdl/dma_subsys_top.sv
  - target: simulation
    files:
      - verif/dma_subsys_tb.sv

//--- dma_subsys_top.f
hdl/dma_reg_pkg.sv
hdl/dma_job_pkg.sv
hdl/dma_fifo.sv
hdl/dma_reg_frontend.sv
hdl/dma_channel.sv
hdl/dma_mem_arbiter.sv
hdl/dma_subsys_top.sv
verif/dma_subsys_tb.sv

//--- hdl/dma_channel.sv
/* Copy channel that moves one job word by word, a read then a write */
`timescale 1ns/1ps

module dma_channel (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 job_start_i,
  input  dma_job_pkg::dma_job_t                job_i,
  output logic                                 busy_o,
  output logic                                 done_o,
  output logic                                 mreq_o,
  output logic                                 mwe_o,
  output logic [dma_job_pkg::MemAddrWidth-1:0] maddr_o,
  output logic [dma_job_pkg::MemDataWidth-1:0] mwdata_o,
  input  logic                                 mgnt_i,
  input  logic                                 mrvalid_i,
  input  logic [dma_job_pkg::MemDataWidth-1:0] mrdata_i
);

  typedef enum logic [1:0] {
    Idle,
    RdReq,
    RdWait,
    WrReq
  } state_e;

  state_e                               state_q;
  logic [dma_job_pkg::MemAddrWidth-1:0] src_q;
  logic [dma_job_pkg::MemAddrWidth-1:0] dst_q;
  logic [dma_job_pkg::LenWidth-1:0]     len_q;
  logic [dma_job_pkg::MemDataWidth-1:0] data_q;

  assign busy_o   = (state_q != Idle);
  assign mreq_o   = (state_q == RdReq) || (state_q == WrReq);
  assign mwe_o    = (state_q == WrReq);
  assign maddr_o  = mwe_o ? dst_q : src_q;
  assign mwdata_o = data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= Idle;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        Idle: begin
          if (job_start_i) begin
            state_q <= RdReq;
          end
        end
        RdReq: begin
          if (mgnt_i) begin
            state_q <= RdWait;
          end
        end
        RdWait: begin
          if (mrvalid_i) begin
            state_q <= WrReq;
          end
        end
        WrReq: begin
          // Last word written ends the job
          if (mgnt_i && (len_q == dma_job_pkg::LenWidth'(1))) begin
            state_q <= Idle;
            done_o  <= 1'b1;
          end else if (mgnt_i) begin
            state_q <= RdReq;
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Pointers, remaining length and the word in flight
  always_ff @(posedge clk_i) begin
    if ((state_q == Idle) && job_start_i) begin
      src_q <= job_i.src;
      dst_q <= job_i.dst;
      len_q <= job_i.len;
    end else if ((state_q == WrReq) && mgnt_i) begin
      src_q <= src_q + 1'b1;
      dst_q <= dst_q + 1'b1;
      len_q <= len_q - 1'b1;
    end
    if ((state_q == RdWait) && mrvalid_i) begin
      data_q <= mrdata_i;
    end
  end

  // An idle channel neither requests nor gets a grant
  assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == Idle) |-> (!mreq_o && !mgnt_i));
  // Read data routed by the arbiter only reaches the channel that asked
  assert property (@(posedge clk_i) disable iff (rst_i) mrvalid_i |-> (state_q == RdWait));

endmodule

//--- hdl/dma_fifo.sv
/* Synchronous FIFO with a type parameter for the stored item */
`timescale 1ns/1ps

module dma_fifo #(
  parameter type         item_t = logic [7:0],
  parameter int unsigned Depth  = 4
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  push_i,
  input  item_t item_i,
  input  logic  pop_i,
  output item_t item_o,
  output logic  empty_o,
  output logic  full_o
);

  localparam int unsigned PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CountWidth = $clog2(Depth + 1);

  item_t                 mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CountWidth-1:0] count_q;
  logic                  do_push;
  logic                  do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CountWidth'(Depth));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head stays visible while not empty
  assign item_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= item_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) !(push_i && full_o));
  assert property (@(posedge clk_i) disable iff (rst_i) !(pop_i && empty_o));

endmodule

//--- hdl/dma_job_pkg.sv
/* Memory word and address widths, job length width and the job descriptor */
package dma_job_pkg;

  // Word addressed memory
  localparam int unsigned MemAddrWidth = 16;
  localparam int unsigned MemDataWidth = 32;

  // Job length in words
  localparam int unsigned LenWidth = 16;

  // One copy job as handed from the frontend to a channel
  typedef struct packed {
    logic [MemAddrWidth-1:0] src;
    logic [MemAddrWidth-1:0] dst;
    logic [LenWidth-1:0]     len;
  } dma_job_t;

endpackage

//--- hdl/dma_mem_arbiter.sv
/* Round-robin arbiter from the copy channels onto one memory port */
`timescale 1ns/1ps

module dma_mem_arbiter #(
  parameter int unsigned NumChannels = 3
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [NumChannels-1:0]               mreq_i,
  input  logic [NumChannels-1:0]               mwe_i,
  input  logic [dma_job_pkg::MemAddrWidth-1:0] maddr_i [NumChannels],
  input  logic [dma_job_pkg::MemDataWidth-1:0] mwdata_i [NumChannels],
  output logic [NumChannels-1:0]               mgnt_o,
  output logic [NumChannels-1:0]               mrvalid_o,
  output logic [dma_job_pkg::MemDataWidth-1:0] mrdata_o,
  output logic                                 mem_req_o,
  output logic                                 mem_we_o,
  output logic [dma_job_pkg::MemAddrWidth-1:0] mem_addr_o,
  output logic [dma_job_pkg::MemDataWidth-1:0] mem_wdata_o,
  input  logic                                 mem_gnt_i,
  input  logic                                 mem_rvalid_i,
  input  logic [dma_job_pkg::MemDataWidth-1:0] mem_rdata_i
);

  localparam int unsigned IdxWidth = (NumChannels > 1) ? $clog2(NumChannels) : 1;

  logic [IdxWidth-1:0] rr_q;
  logic [IdxWidth-1:0] rr_sel;
  logic [IdxWidth-1:0] sel;
  logic [IdxWidth-1:0] hold_idx_q;
  logic [IdxWidth-1:0] rd_owner_q;
  logic                rr_found;
  logic                hold_q;
  logic                xfer;

  // First requester at or after the pointer
  always_comb begin
    int unsigned idx;
    rr_sel   = rr_q;
    rr_found = 1'b0;
    for (int unsigned k = 0; k < NumChannels; k++) begin
      idx = (32'(rr_q) + k) % NumChannels;
      if (!rr_found && mreq_i[idx]) begin
        rr_found = 1'b1;
        rr_sel   = IdxWidth'(idx);
      end
    end
  end

  // A stalled request keeps its channel until granted
  assign sel         = hold_q ? hold_idx_q : rr_sel;
  assign mem_req_o   = hold_q || rr_found;
  assign mem_we_o    = mwe_i[sel];
  assign mem_addr_o  = maddr_i[sel];
  assign mem_wdata_o = mwdata_i[sel];
  assign xfer        = mem_req_o && mem_gnt_i;
  assign mrdata_o    = mem_rdata_i;

  always_comb begin
    mgnt_o    = '0;
    mrvalid_o = '0;
    if (xfer) begin
      mgnt_o[sel] = 1'b1;
    end
    if (mem_rvalid_i) begin
      mrvalid_o[rd_owner_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q       <= '0;
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
      rd_owner_q <= '0;
    end else if (xfer) begin
      hold_q <= 1'b0;
      rr_q   <= (sel == IdxWidth'(NumChannels - 1)) ? '0 : sel + 1'b1;
      if (!mem_we_o) begin
        rd_owner_q <= sel;
      end
    end else if (mem_req_o) begin
      hold_q     <= 1'b1;
      hold_idx_q <= sel;
    end
  end

  // Grants are one-hot and only reach a channel that still requests
  assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(mgnt_o) && ((mgnt_o & ~mreq_i) == '0));
  // Memory returns data only right after a granted read
  assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rvalid_i |-> $past(xfer && !mem_we_o));

endmodule

//--- hdl/dma_reg_frontend.sv
/* Register frontend: staging registers, launch decode, job queue,
   channel dispatch, completion counter and interrupt */
`timescale 1ns/1ps

module dma_reg_frontend #(
  parameter int unsigned NumChannels   = 3,
  parameter int unsigned JobQueueDepth = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 reg_valid_i,
  input  logic                                 reg_write_i,
  input  logic [dma_reg_pkg::RegAddrWidth-1:0] reg_addr_i,
  input  logic [dma_reg_pkg::RegDataWidth-1:0] reg_wdata_i,
  output logic                                 reg_ready_o,
  output logic [dma_reg_pkg::RegDataWidth-1:0] reg_rdata_o,
  output logic [NumChannels-1:0]               job_start_o,
  output dma_job_pkg::dma_job_t                job_o [NumChannels],
  input  logic [NumChannels-1:0]               busy_i,
  input  logic [NumChannels-1:0]               done_i,
  output logic                                 irq_o
);

  logic                                  accept;
  logic                                  launch;
  logic                                  status_wr;
  logic [dma_job_pkg::MemAddrWidth-1:0]  src_q;
  logic [dma_job_pkg::MemAddrWidth-1:0]  dst_q;
  logic [dma_job_pkg::LenWidth-1:0]      len_q;
  logic                                  reject_q;
  logic [dma_reg_pkg::RegDataWidth-1:0]  done_count_q;
  logic [dma_reg_pkg::RegDataWidth-1:0]  done_sum;
  logic [dma_reg_pkg::RegDataWidth-1:0]  status_word;
  logic [dma_reg_pkg::RegDataWidth-1:0]  rdata_d;
  dma_job_pkg::dma_job_t                 new_job;
  dma_job_pkg::dma_job_t                 head_job;
  logic                                  q_push;
  logic                                  q_pop;
  logic                                  q_empty;
  logic                                  q_full;
  logic [NumChannels-1:0]                idle_pick;

  // New access seen while no response is pending
  assign accept    = reg_valid_i && !reg_ready_o;
  assign launch    = accept && reg_write_i && (reg_addr_i == dma_reg_pkg::LaunchOffset);
  assign status_wr = accept && reg_write_i && (reg_addr_i == dma_reg_pkg::StatusOffset);
  assign q_push    = launch && (len_q != '0) && !q_full;
  assign new_job   = '{src: src_q, dst: dst_q, len: len_q};

  always_ff @(posedge clk_i) begin
    if (accept && reg_write_i) begin
      case (reg_addr_i)
        dma_reg_pkg::SrcOffset: src_q <= reg_wdata_i[dma_job_pkg::MemAddrWidth-1:0];
        dma_reg_pkg::DstOffset: dst_q <= reg_wdata_i[dma_job_pkg::MemAddrWidth-1:0];
        dma_reg_pkg::LenOffset: len_q <= reg_wdata_i[dma_job_pkg::LenWidth-1:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    status_word = '0;
    status_word[dma_reg_pkg::StatusBusyBit]      = (busy_i != '0) || !q_empty;
    status_word[dma_reg_pkg::StatusQueueFullBit] = q_full;
    status_word[dma_reg_pkg::StatusRejectBit]    = reject_q;
  end

  always_comb begin
    case (reg_addr_i)
      dma_reg_pkg::SrcOffset:       rdata_d = dma_reg_pkg::RegDataWidth'(src_q);
      dma_reg_pkg::DstOffset:       rdata_d = dma_reg_pkg::RegDataWidth'(dst_q);
      dma_reg_pkg::LenOffset:       rdata_d = dma_reg_pkg::RegDataWidth'(len_q);
      dma_reg_pkg::StatusOffset:    rdata_d = status_word;
      dma_reg_pkg::DoneCountOffset: rdata_d = done_count_q;
      default:                      rdata_d = '0;
    endcase
  end

  // Number of channels finishing this cycle
  always_comb begin
    done_sum = '0;
    for (int c = 0; c < NumChannels; c++) begin
      done_sum = done_sum + dma_reg_pkg::RegDataWidth'(done_i[c]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_ready_o  <= 1'b0;
      reg_rdata_o  <= '0;
      reject_q     <= 1'b0;
      done_count_q <= '0;
      irq_o        <= 1'b0;
    end else begin
      reg_ready_o <= accept;
      if (accept) begin
        reg_rdata_o <= rdata_d;
      end
      // Zero length or full queue drops the launch
      if (launch && !q_push) begin
        reject_q <= 1'b1;
      end else if (status_wr) begin
        reject_q <= 1'b0;
      end
      done_count_q <= done_count_q + done_sum;
      irq_o        <= (done_i != '0);
    end
  end

  dma_fifo #(
    .item_t (dma_job_pkg::dma_job_t),
    .Depth  (JobQueueDepth)
  ) i_job_queue (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (q_push),
    .item_i  (new_job),
    .pop_i   (q_pop),
    .item_o  (head_job),
    .empty_o (q_empty),
    .full_o  (q_full)
  );

  // Lowest numbered idle channel takes the queue head
  always_comb begin
    idle_pick = '0;
    for (int c = 0; c < NumChannels; c++) begin
      if (!busy_i[c] && (idle_pick == '0)) begin
        idle_pick[c] = 1'b1;
      end
    end
  end

  assign job_start_o = q_empty ? '0 : idle_pick;
  assign q_pop       = !q_empty && (idle_pick != '0);

  always_comb begin
    for (int c = 0; c < NumChannels; c++) begin
      job_o[c] = head_job;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(job_start_o));
  // A started channel reports busy in the next cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
    (job_start_o != '0) |=> ((busy_i & $past(job_start_o)) == $past(job_start_o)));

endmodule

//--- hdl/dma_reg_pkg.sv
/* Register bus widths, register offsets and status bit positions
   of the DMA copy subsystem */
package dma_reg_pkg;

  // Register bus geometry
  localparam int unsigned RegAddrWidth = 6;
  localparam int unsigned RegDataWidth = 32;

  // Byte offsets of the register map
  localparam logic [RegAddrWidth-1:0] SrcOffset       = 6'h00;
  localparam logic [RegAddrWidth-1:0] DstOffset       = 6'h04;
  localparam logic [RegAddrWidth-1:0] LenOffset       = 6'h08;
  localparam logic [RegAddrWidth-1:0] LaunchOffset    = 6'h0C;
  localparam logic [RegAddrWidth-1:0] StatusOffset    = 6'h10;
  localparam logic [RegAddrWidth-1:0] DoneCountOffset = 6'h14;

  // Status word bits
  localparam int unsigned StatusBusyBit      = 0;
  localparam int unsigned StatusQueueFullBit = 1;
  // Sticky, cleared by any write to STATUS
  localparam int unsigned StatusRejectBit    = 2;

endpackage

//--- hdl/dma_subsys_top.sv
/* DMA copy subsystem top: frontend, copy channels and memory arbiter */
`timescale 1ns/1ps

module dma_subsys_top #(
  parameter int unsigned NumChannels   = 3,
  parameter int unsigned JobQueueDepth = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 reg_valid_i,
  input  logic                                 reg_write_i,
  input  logic [dma_reg_pkg::RegAddrWidth-1:0] reg_addr_i,
  input  logic [dma_reg_pkg::RegDataWidth-1:0] reg_wdata_i,
  output logic                                 reg_ready_o,
  output logic [dma_reg_pkg::RegDataWidth-1:0] reg_rdata_o,
  output logic                                 irq_o,
  output logic                                 mem_req_o,
  output logic                                 mem_we_o,
  output logic [dma_job_pkg::MemAddrWidth-1:0] mem_addr_o,
  output logic [dma_job_pkg::MemDataWidth-1:0] mem_wdata_o,
  input  logic                                 mem_gnt_i,
  input  logic                                 mem_rvalid_i,
  input  logic [dma_job_pkg::MemDataWidth-1:0] mem_rdata_i
);

  // Frontend to channels
  logic [NumChannels-1:0]               job_start;
  dma_job_pkg::dma_job_t                job [NumChannels];
  logic [NumChannels-1:0]               busy;
  logic [NumChannels-1:0]               done;

  // Channels to arbiter
  logic [NumChannels-1:0]               mreq;
  logic [NumChannels-1:0]               mwe;
  logic [dma_job_pkg::MemAddrWidth-1:0] maddr [NumChannels];
  logic [dma_job_pkg::MemDataWidth-1:0] mwdata [NumChannels];
  logic [NumChannels-1:0]               mgnt;
  logic [NumChannels-1:0]               mrvalid;
  logic [dma_job_pkg::MemDataWidth-1:0] mrdata;

  dma_reg_frontend #(
    .NumChannels   (NumChannels),
    .JobQueueDepth (JobQueueDepth)
  ) i_frontend (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_ready_o (reg_ready_o),
    .reg_rdata_o (reg_rdata_o),
    .job_start_o (job_start),
    .job_o       (job),
    .busy_i      (busy),
    .done_i      (done),
    .irq_o       (irq_o)
  );

  for (genvar i = 0; i < NumChannels; i++) begin : g_chan
    dma_channel i_channel (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .job_start_i (job_start[i]),
      .job_i       (job[i]),
      .busy_o      (busy[i]),
      .done_o      (done[i]),
      .mreq_o      (mreq[i]),
      .mwe_o       (mwe[i]),
      .maddr_o     (maddr[i]),
      .mwdata_o    (mwdata[i]),
      .mgnt_i      (mgnt[i]),
      .mrvalid_i   (mrvalid[i]),
      .mrdata_i    (mrdata)
    );
  end

  dma_mem_arbiter #(
    .NumChannels (NumChannels)
  ) i_arbiter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .mreq_i       (mreq),
    .mwe_i        (mwe),
    .maddr_i      (maddr),
    .mwdata_i     (mwdata),
    .mgnt_o       (mgnt),
    .mrvalid_o    (mrvalid),
    .mrdata_o     (mrdata),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

endmodule

//--- verif/dma_subsys_tb.sv
/* Testbench for the DMA copy subsystem: clock, reset, memory model with
   grant stalls, job table, register tasks and result checks */
`timescale 1ns/1ps

module dma_subsys_tb;

  localparam int unsigned NumChannels   = 3;
  localparam int unsigned JobQueueDepth = 4;
  localparam int unsigned NumJobs       = 10;
  localparam int unsigned MaxLen        = 16;
  localparam int unsigned ReadyTimeout  = 20;
  localparam int unsigned PollTimeout   = 3000;
  localparam int unsigned MemWords      = 1 << dma_job_pkg::MemAddrWidth;

  typedef struct packed {
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] len;
    logic        expect_reject;
  } job_entry_t;

  logic                                 clk_i;
  logic                                 rst_i;
  logic                                 reg_valid_i;
  logic                                 reg_write_i;
  logic [dma_reg_pkg::RegAddrWidth-1:0] reg_addr_i;
  logic [dma_reg_pkg::RegDataWidth-1:0] reg_wdata_i;
  logic                                 reg_ready_o;
  logic [dma_reg_pkg::RegDataWidth-1:0] reg_rdata_o;
  logic                                 irq_o;
  logic                                 mem_req_o;
  logic                                 mem_we_o;
  logic [dma_job_pkg::MemAddrWidth-1:0] mem_addr_o;
  logic [dma_job_pkg::MemDataWidth-1:0] mem_wdata_o;
  logic                                 mem_gnt_i;
  logic                                 mem_rvalid_i;
  logic [dma_job_pkg::MemDataWidth-1:0] mem_rdata_i;

  job_entry_t  jobs [NumJobs];
  logic [31:0] src_data [NumJobs][MaxLen];
  logic [31:0] mem [MemWords];
  logic [31:0] lcg_state = 32'h5c7c5ba4;
  int unsigned grant_mode;
  int unsigned irq_pulses;
  logic        xfer_seen;
  logic        xfer_we;
  logic [15:0] xfer_addr;
  logic [31:0] xfer_wdata;
  logic        next_gnt;

  dma_subsys_top #(
    .NumChannels   (NumChannels),
    .JobQueueDepth (JobQueueDepth)
  ) uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_ready_o  (reg_ready_o),
    .reg_rdata_o  (reg_rdata_o),
    .irq_o        (irq_o),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Background pattern, different for every address
  function automatic logic [31:0] fill_word(input logic [15:0] addr);
    return {~addr, addr};
  endfunction

  // Port sampled mid-cycle where all DUT outputs have settled
  always @(negedge clk_i) begin
    xfer_seen  = !rst_i && mem_req_o && mem_gnt_i;
    xfer_we    = mem_we_o;
    xfer_addr  = mem_addr_o;
    xfer_wdata = mem_wdata_o;
    // 0 grants always, 1 withholds about 3 in 8, 2 never grants
    case (grant_mode)
      0:       next_gnt = 1'b1;
      1:       next_gnt = (next_random() >> 29) >= 3;
      default: next_gnt = 1'b0;
    endcase
    if (!rst_i && irq_o) begin
      irq_pulses++;
    end
  end

  always @(posedge clk_i) begin
    #1;
    if (xfer_seen && xfer_we) begin
      mem[xfer_addr] = xfer_wdata;
    end
    mem_rvalid_i = xfer_seen && !xfer_we;
    mem_rdata_i  = (xfer_seen && !xfer_we) ? mem[xfer_addr] : '0;
    xfer_seen    = 1'b0;
    mem_gnt_i    = next_gnt;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Test failed");
    $fatal(1);
  endtask

  // One register access, held until ready
  task automatic reg_access(input logic wr, input logic [5:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int unsigned cycles;
    reg_valid_i = 1'b1;
    reg_write_i = wr;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    cycles      = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (cycles > ReadyTimeout) begin
        report_timeout("reg_ready_o");
      end
    end while (!reg_ready_o);
    rdata       = reg_rdata_o;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic reg_write(input logic [5:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    reg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_read(input logic [5:0] addr, output logic [31:0] rdata);
    reg_access(1'b0, addr, '0, rdata);
  endtask

  task automatic add_job_entry(input int idx, input logic [15:0] src,
                               input logic [15:0] dst, input logic [15:0] len,
                               input logic rej);
    jobs[idx] = {src, dst, len, rej};
  endtask

  // Program one table entry and check the sticky reject bit
  task automatic apply_job(input int idx);
    logic [31:0] status;
    reg_write(dma_reg_pkg::SrcOffset, 32'(jobs[idx].src));
    reg_write(dma_reg_pkg::DstOffset, 32'(jobs[idx].dst));
    reg_write(dma_reg_pkg::LenOffset, 32'(jobs[idx].len));
    reg_write(dma_reg_pkg::LaunchOffset, 32'h1);
    reg_read(dma_reg_pkg::StatusOffset, status);
    check_value("STATUS reject", 32'(status[dma_reg_pkg::StatusRejectBit]),
                32'(jobs[idx].expect_reject));
    if (jobs[idx].expect_reject) begin
      reg_write(dma_reg_pkg::StatusOffset, 32'h0);
      reg_read(dma_reg_pkg::StatusOffset, status);
      check_value("STATUS reject after clear",
                  32'(status[dma_reg_pkg::StatusRejectBit]), 32'h0);
    end
  endtask

  // Poll DONE_COUNT, busy must stay high while jobs are pending
  task automatic wait_done_count(input logic [31:0] expected);
    logic [31:0] status;
    logic [31:0] count;
    int unsigned polls;
    polls = 0;
    count = '0;
    while (count != expected) begin
      reg_read(dma_reg_pkg::StatusOffset, status);
      reg_read(dma_reg_pkg::DoneCountOffset, count);
      if (count < expected) begin
        check_value("STATUS busy", 32'(status[dma_reg_pkg::StatusBusyBit]), 32'h1);
      end
      polls++;
      if (polls > PollTimeout) begin
        report_timeout("DONE_COUNT to reach the accepted job count");
      end
    end
  endtask

  // Accepted jobs copy their source, rejected ones leave dst alone
  task automatic check_copy(input int idx);
    logic [15:0] addr;
    logic [31:0] exp;
    for (int k = 0; k < int'(jobs[idx].len); k++) begin
      addr = jobs[idx].dst + 16'(k);
      exp  = jobs[idx].expect_reject ? fill_word(addr) : src_data[idx][k];
      check_value($sformatf("mem[%h]", addr), mem[addr], exp);
    end
  endtask

  initial begin
    logic [31:0] rdata;
    int unsigned accepted;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    xfer_seen    = 1'b0;
    next_gnt     = 1'b0;
    grant_mode   = 0;
    irq_pulses   = 0;
    accepted     = 0;

    // Entries 2..8 fill 3 channels and 4 queue slots while grants are off
    add_job_entry(0, 16'h0100, 16'h1100, 16'd5,  1'b0);
    add_job_entry(1, 16'h0200, 16'h1200, 16'd0,  1'b1);
    add_job_entry(2, 16'h0300, 16'h1300, 16'd7,  1'b0);
    add_job_entry(3, 16'h0400, 16'h1400, 16'd3,  1'b0);
    add_job_entry(4, 16'h0500, 16'h1500, 16'd9,  1'b0);
    add_job_entry(5, 16'h0600, 16'h1600, 16'd1,  1'b0);
    add_job_entry(6, 16'h0700, 16'h1700, 16'd16, 1'b0);
    add_job_entry(7, 16'h0800, 16'h1800, 16'd4,  1'b0);
    add_job_entry(8, 16'h0900, 16'h1900, 16'd8,  1'b0);
    add_job_entry(9, 16'h0A00, 16'h1A00, 16'd5,  1'b1);

    for (int a = 0; a < MemWords; a++) begin
      mem[a] = fill_word(16'(a));
    end
    for (int j = 0; j < NumJobs; j++) begin
      if (!jobs[j].expect_reject) begin
        accepted++;
      end
      for (int k = 0; k < MaxLen; k++) begin
        src_data[j][k] = next_random();
        mem[jobs[j].src + 16'(k)] = src_data[j][k];
      end
    end

    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Reset state and staging register read back
    check_value("irq_o", 32'(irq_o), 32'h0);
    check_value("mem_req_o", 32'(mem_req_o), 32'h0);
    reg_read(dma_reg_pkg::StatusOffset, rdata);
    check_value("STATUS", rdata, 32'h0);
    reg_read(dma_reg_pkg::DoneCountOffset, rdata);
    check_value("DONE_COUNT", rdata, 32'h0);
    reg_write(dma_reg_pkg::SrcOffset, 32'h0000_1234);
    reg_write(dma_reg_pkg::DstOffset, 32'h0000_BEEF);
    reg_write(dma_reg_pkg::LenOffset, 32'h0000_0042);
    reg_read(dma_reg_pkg::SrcOffset, rdata);
    check_value("SRC", rdata, 32'h0000_1234);
    reg_read(dma_reg_pkg::DstOffset, rdata);
    check_value("DST", rdata, 32'h0000_BEEF);
    reg_read(dma_reg_pkg::LenOffset, rdata);
    check_value("LEN", rdata, 32'h0000_0042);

    // Single job, then a zero length launch
    apply_job(0);
    wait_done_count(32'd1);
    check_value("irq_o pulse count", irq_pulses, 32'd1);
    check_copy(0);
    apply_job(1);
    reg_read(dma_reg_pkg::DoneCountOffset, rdata);
    check_value("DONE_COUNT", rdata, 32'd1);

    // Back to back launches with the memory stalled
    grant_mode = 2;
    for (int j = 2; j < NumJobs; j++) begin
      apply_job(j);
    end
    reg_read(dma_reg_pkg::StatusOffset, rdata);
    check_value("STATUS", rdata, (32'h1 << dma_reg_pkg::StatusBusyBit) |
                                 (32'h1 << dma_reg_pkg::StatusQueueFullBit));

    grant_mode = 1;
    wait_done_count(32'(accepted));
    reg_read(dma_reg_pkg::StatusOffset, rdata);
    check_value("STATUS", rdata, 32'h0);
    reg_read(dma_reg_pkg::DoneCountOffset, rdata);
    check_value("DONE_COUNT", rdata, 32'(accepted));
    for (int j = 0; j < NumJobs; j++) begin
      check_copy(j);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule
